/* extract_cfg.svh */
// Size settings for the instruction-extract stage: lane count, line and word widths
`ifndef EXTRACT_CFG_SVH
`define EXTRACT_CFG_SVH

// ====================
// Lane geometry
// ====================

// Number of decode lanes fed each cycle
// This fixes the generate loop and every flattened port width
`define EXT_LANES 4

// ====================
// Data widths
// ====================

// Instruction-cache line width in bits, 32 bytes
`define EXT_LINE_BITS 256

// One instruction word
`define EXT_INS_BITS 32

`endif

/* extract_pkg.sv */
// Shared types for the extract stage: opcode and source enums plus instruction field positions
package extract_pkg;

	// ====================
	// Enumerations
	// ====================

	// Major opcode held in the low seven bits of every instruction
	// An all-zero word decodes as a NOP and marks an empty slot
	typedef enum logic [6:0] {
		OP_NOP     = 7'h00,
		OP_ALU     = 7'h33,
		OP_SYS     = 7'h73,
		OP_REGLIST = 7'h2f
	} opcode_e;

	// Where the whole extraction group comes from this cycle
	typedef enum logic [1:0] {
		SRC_LINE  = 2'd0,
		SRC_MCODE = 2'd1,
		SRC_IRQ   = 2'd2,
		SRC_RLIST = 2'd3
	} src_sel_e;

	// ====================
	// Field positions
	// ====================

	// Top bit of the opcode field, which starts at bit 0
	localparam int OPC_MSB = 6;

	// Destination register
	localparam int RD_LSB = 7;
	localparam int RD_MSB = 11;

	// Register count of a register-list instruction
	localparam int CNT_LSB = 12;
	localparam int CNT_MSB = 16;

	// Interrupt level and vector inside the synthesized system word
	localparam int LVL_LSB = 12;
	localparam int LVL_MSB = 14;
	localparam int VEC_LSB = 15;
	localparam int VEC_MSB = 23;

endpackage

/* extract_ctrl.sv */
// Extract feeder: picks the group's source and builds the interrupt word and register-list head
`timescale 1ns/1ps
`include "extract_cfg.svh"

module extract_ctrl (
	input  logic [`EXT_LINE_BITS-1:0] line_i,
	input  logic [4:0]                pc_off0_i,
	input  logic                      mc_valid_i,
	input  logic                      irq_req_i,
	input  logic [2:0]                irq_level_i,
	input  logic [2:0]                irq_mask_i,
	input  logic [8:0]                irq_vect_i,
	output extract_pkg::src_sel_e     sel_o,
	output logic [`EXT_INS_BITS-1:0]  irq_word_o,
	output logic [`EXT_INS_BITS-1:0]  head_word_o
);
	import extract_pkg::*;

	// Line shifted down to lane 0's byte offset
	logic [`EXT_LINE_BITS-1:0] line_shift;
	// High when the pending interrupt beats the current mask
	logic irq_take;

	// ====================
	// Lane 0 head word
	// ====================

	// Bytes past the end of the line shift in as zero
	assign line_shift = line_i >> {pc_off0_i, 3'b000};
	assign head_word_o = line_shift[`EXT_INS_BITS-1:0];

	// An interrupt needs a level strictly above the mask
	// A running microcode sequence must finish first, so it blocks the request
	assign irq_take = irq_req_i && (irq_level_i > irq_mask_i) && !mc_valid_i;

	// ====================
	// Source priority
	// ====================

	// One source applies to all lanes of the group
	always_comb begin
		if (irq_take) begin
			sel_o = SRC_IRQ;
		end else if (mc_valid_i) begin
			sel_o = SRC_MCODE;
		end else if (head_word_o[OPC_MSB:0] == OP_REGLIST) begin
			// Lane 0 holds a register list, so it is spread over the lanes
			sel_o = SRC_RLIST;
		end else begin
			sel_o = SRC_LINE;
		end
	end

	// System word that carries the interrupt into the stream
	// Everything outside opcode, level and vector stays zero, destination included
	always_comb begin
		irq_word_o = '0;
		irq_word_o[OPC_MSB:0] = OP_SYS;
		irq_word_o[LVL_MSB:LVL_LSB] = irq_level_i;
		irq_word_o[VEC_MSB:VEC_LSB] = irq_vect_i;
	end

endmodule

/* extract_lane.sv */
// Extract lane: forms one decode lane's instruction from the source chosen by the feeder
`timescale 1ns/1ps
`include "extract_cfg.svh"

module extract_lane #(
	// Position of this lane, used as the register-list step
	parameter int LANE_IDX = 0
) (
	input  extract_pkg::src_sel_e     sel_i,
	input  logic [`EXT_LINE_BITS-1:0] line_i,
	input  logic [4:0]                pc_off_i,
	input  logic [`EXT_INS_BITS-1:0]  mc_ins_i,
	input  logic [`EXT_INS_BITS-1:0]  irq_word_i,
	input  logic [`EXT_INS_BITS-1:0]  head_word_i,
	output logic [`EXT_INS_BITS-1:0]  ins_o
);
	import extract_pkg::*;

	// Lane index narrowed to the register field width
	localparam logic [4:0] LANE_OFF = 5'(LANE_IDX);

	// Line shifted down to this lane's byte offset
	logic [`EXT_LINE_BITS-1:0] line_shift;
	// Word taken straight from the cache line
	logic [`EXT_INS_BITS-1:0] line_word;
	// Base register and count carried by the head word
	logic [4:0] rl_base;
	logic [4:0] rl_cnt;
	// This lane's share of a register list
	logic [`EXT_INS_BITS-1:0] rlist_word;

	// ====================
	// Line extraction
	// ====================

	// Offsets near the end of the line pull in zero bytes from the shift
	assign line_shift = line_i >> {pc_off_i, 3'b000};
	assign line_word = line_shift[`EXT_INS_BITS-1:0];

	// ====================
	// Register-list expansion
	// ====================

	assign rl_base = head_word_i[RD_MSB:RD_LSB];
	assign rl_cnt = head_word_i[CNT_MSB:CNT_LSB];

	// Lanes below the count repeat the head with a stepped destination
	// The 5-bit add wraps the register number past 31 back to 0
	always_comb begin
		rlist_word = '0;
		if (LANE_OFF < rl_cnt) begin
			rlist_word = head_word_i;
			rlist_word[RD_MSB:RD_LSB] = rl_base + LANE_OFF;
		end
	end

	// ====================
	// Source select
	// ====================

	// Microcode and interrupt words pass through untouched
	always_comb begin
		case (sel_i)
			SRC_MCODE: ins_o = mc_ins_i;
			SRC_IRQ:   ins_o = irq_word_i;
			SRC_RLIST: ins_o = rlist_word;
			default:   ins_o = line_word;
		endcase
	end

endmodule

/* extract_out.sv */
// Extract drain: pipeline register for all lane words with per-slot valid flags
`timescale 1ns/1ps
`include "extract_cfg.svh"

module extract_out (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 en_i,
	input  logic [`EXT_LANES*`EXT_INS_BITS-1:0]  lane_ins_i,
	output logic [`EXT_LANES*`EXT_INS_BITS-1:0]  ins_o,
	output logic [`EXT_LANES-1:0]                slot_valid_o
);
	import extract_pkg::*;

	// Registered group, lane 0 in the low word
	logic [`EXT_LANES*`EXT_INS_BITS-1:0] ins_q;

	// ====================
	// Pipeline register
	// ====================

	// Reset fills every slot with the all-zero NOP word
	// With the enable low the previous group is held
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ins_q <= '0;
		end else if (en_i) begin
			ins_q <= lane_ins_i;
		end
	end

	assign ins_o = ins_q;

	// ====================
	// Slot flags
	// ====================

	// A slot is filled whenever its opcode is anything but NOP
	always_comb begin
		for (int i = 0; i < `EXT_LANES; i++) begin
			slot_valid_o[i] = (ins_q[i*`EXT_INS_BITS +: OPC_MSB+1] != OP_NOP);
		end
	end

endmodule

/* extract_ins.sv */
// Instruction-extract stage: feeder, per-lane extraction and the output register
`timescale 1ns/1ps
`include "extract_cfg.svh"

module extract_ins (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic                                en_i,
	input  logic [`EXT_LINE_BITS-1:0]           line_i,
	input  logic [`EXT_LANES*5-1:0]             pc_off_i,
	input  logic                                mc_valid_i,
	input  logic [`EXT_LANES*`EXT_INS_BITS-1:0] mc_ins_i,
	input  logic                                irq_req_i,
	input  logic [2:0]                          irq_level_i,
	input  logic [2:0]                          irq_mask_i,
	input  logic [8:0]                          irq_vect_i,
	output logic [`EXT_LANES*`EXT_INS_BITS-1:0] ins_o,
	output logic [`EXT_LANES-1:0]               slot_valid_o
);
	import extract_pkg::*;

	// Group source shared by every lane
	src_sel_e sel;
	// Synthesized system word for interrupt entry
	logic [`EXT_INS_BITS-1:0] irq_word;
	// Lane 0 word, the head of a possible register list
	logic [`EXT_INS_BITS-1:0] head_word;
	// Combinational lane results on their way to the register
	logic [`EXT_LANES*`EXT_INS_BITS-1:0] lane_ins;

	// ====================
	// Feeder
	// ====================

	// Only lane 0's offset matters for the register-list check
	extract_ctrl ctrl_inst (
		.line_i      (line_i),
		.pc_off0_i   (pc_off_i[4:0]),
		.mc_valid_i  (mc_valid_i),
		.irq_req_i   (irq_req_i),
		.irq_level_i (irq_level_i),
		.irq_mask_i  (irq_mask_i),
		.irq_vect_i  (irq_vect_i),
		.sel_o       (sel),
		.irq_word_o  (irq_word),
		.head_word_o (head_word)
	);

	// ====================
	// Lanes
	// ====================

	// Each lane sees the whole line plus its own offset and microcode word
	for (genvar gi = 0; gi < `EXT_LANES; gi++) begin : g_lane
		extract_lane #(
			.LANE_IDX (gi)
		) lane_inst (
			.sel_i       (sel),
			.line_i      (line_i),
			.pc_off_i    (pc_off_i[gi*5 +: 5]),
			.mc_ins_i    (mc_ins_i[gi*`EXT_INS_BITS +: `EXT_INS_BITS]),
			.irq_word_i  (irq_word),
			.head_word_i (head_word),
			.ins_o       (lane_ins[gi*`EXT_INS_BITS +: `EXT_INS_BITS])
		);
	end

	// ====================
	// Drain
	// ====================

	// One cycle from input sample to ins_o and slot_valid_o
	extract_out out_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.en_i         (en_i),
		.lane_ins_i   (lane_ins),
		.ins_o        (ins_o),
		.slot_valid_o (slot_valid_o)
	);

endmodule

/* extract_assert.sv */
// Output checks for the extract stage: valid flags, hold with enable low, clear after reset
`timescale 1ns/1ps
`include "extract_cfg.svh"

module extract_assert (
	input logic                                clk,
	input logic                                rst_n_i,
	input logic                                en_i,
	input logic [`EXT_LANES*`EXT_INS_BITS-1:0] ins_o,
	input logic [`EXT_LANES-1:0]               slot_valid_o
);
	import extract_pkg::*;

	// A raised flag always sits on a real opcode
	for (genvar gi = 0; gi < `EXT_LANES; gi++) begin : g_slot
		valid_has_opcode: assert property (@(posedge clk)
			slot_valid_o[gi] |-> (ins_o[gi*`EXT_INS_BITS +: OPC_MSB+1] != OP_NOP))
			else $error("Slot %0d is flagged valid but holds a NOP opcode", gi);
	end

	// The register loads nothing on an edge where the enable was low
	hold_when_disabled: assert property (@(posedge clk)
		(!$past(en_i) && $past(rst_n_i)) |-> $stable(ins_o))
		else $error("Outputs changed although the enable was low");

	// One edge of reset is enough to empty every slot
	clear_after_reset: assert property (@(posedge clk)
		$past(!rst_n_i) |-> (slot_valid_o == '0))
		else $error("Slot flags still set one cycle after reset");

endmodule

bind extract_ins extract_assert extract_assert_inst (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.en_i         (en_i),
	.ins_o        (ins_o),
	.slot_valid_o (slot_valid_o)
);

/* tb_extract_ins.sv */
// Directed testbench for the instruction-extract stage, checked against a model of the source rules
`timescale 1ns/1ps
`include "extract_cfg.svh"

module tb_extract_ins;
	import extract_pkg::*;

	localparam int LANES = `EXT_LANES;
	localparam int WB = `EXT_INS_BITS;
	// The tests need about 50 cycles, so 400 leaves a wide margin
	localparam int MAX_CYCLES = 400;

	logic clk;
	logic rst_n_i;
	logic en_i;
	logic [`EXT_LINE_BITS-1:0] line_i;
	logic [LANES*5-1:0] pc_off_i;
	logic mc_valid_i;
	logic [LANES*WB-1:0] mc_ins_i;
	logic irq_req_i;
	logic [2:0] irq_level_i;
	logic [2:0] irq_mask_i;
	logic [8:0] irq_vect_i;
	logic [LANES*WB-1:0] ins_o;
	logic [LANES-1:0] slot_valid_o;

	// Expected word per lane for the group last captured
	logic [WB-1:0] exp_w [LANES];
	logic [31:0] lcg_state = 32'd71;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	extract_ins extract_ins_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// A stuck run still ends here
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ====================
	// Reference model
	// ====================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Four bytes from a byte offset, reading zero past the last byte of the line
	function automatic logic [WB-1:0] pick_bytes(input int off);
		logic [WB-1:0] w;
		w = '0;
		for (int b = 0; b < 4; b++) begin
			if (off + b < `EXT_LINE_BITS/8)
				w[b*8 +: 8] = line_i[(off+b)*8 +: 8];
		end
		return w;
	endfunction

	// Expected lane words from the inputs held since the capture edge
	task automatic compute_expected();
		logic [WB-1:0] head;
		logic [WB-1:0] w;
		head = pick_bytes(int'(pc_off_i[4:0]));
		for (int i = 0; i < LANES; i++) begin
			w = pick_bytes(int'(pc_off_i[i*5 +: 5]));
			if (irq_req_i && irq_level_i > irq_mask_i && !mc_valid_i) begin
				// Upper zero byte, vector, level, zero destination, opcode
				w = {8'd0, irq_vect_i, irq_level_i, 5'd0, OP_SYS};
			end else if (mc_valid_i) begin
				w = mc_ins_i[i*WB +: WB];
			end else if (head[OPC_MSB:0] == OP_REGLIST) begin
				w = '0;
				if (i < int'(head[CNT_MSB:CNT_LSB])) begin
					w = head;
					w[RD_MSB:RD_LSB] = 5'((int'(head[RD_MSB:RD_LSB]) + i) % 32);
				end
			end
			exp_w[i] = w;
		end
	endtask

	task automatic check_outputs();
		logic [WB-1:0] got;
		for (int i = 0; i < LANES; i++) begin
			got = ins_o[i*WB +: WB];
			checks++;
			assert (got == exp_w[i]) else begin
				errors++;
				$display("[ERROR] %0t ins_o lane %0d expected %h actual %h",
					$time, i, exp_w[i], got);
			end
			assert (slot_valid_o[i] == (exp_w[i][OPC_MSB:0] != 7'd0)) else begin
				errors++;
				$display("[ERROR] %0t slot_valid_o[%0d] expected %0b actual %0b",
					$time, i, exp_w[i][OPC_MSB:0] != 7'd0, slot_valid_o[i]);
			end
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	// Random line and offsets on the next edge with no microcode and no interrupt
	// Callers may override single inputs right after, in the same time step
	task automatic random_group();
		logic [31:0] r;
		@(posedge clk);
		for (int k = 0; k < `EXT_LINE_BITS/32; k++) begin
			line_i[k*32 +: 32] <= lcg_next();
		end
		r = lcg_next();
		pc_off_i <= r[LANES*5-1:0];
		en_i <= 1'b1;
		mc_valid_i <= 1'b0;
		irq_req_i <= 1'b0;
	endtask

	// The DUT captures on the next edge and the outputs are read at the falling edge
	task automatic capture_and_check();
		@(posedge clk);
		@(negedge clk);
		compute_expected();
		check_outputs();
	endtask

	task automatic test_line_extract();
		for (int n = 0; n < 8; n++) begin
			random_group();
			capture_and_check();
		end
		// Offsets at the end of the line pull in zero bytes
		random_group();
		pc_off_i <= {5'd31, 5'd30, 5'd29, 5'd28};
		capture_and_check();
	endtask

	task automatic test_mcode_override();
		for (int n = 0; n < 2; n++) begin
			random_group();
			for (int k = 0; k < LANES; k++) begin
				mc_ins_i[k*WB +: WB] <= lcg_next();
			end
			// Empty last microcode slot, so its flag has to drop
			mc_ins_i[LANES*WB-1 -: WB] <= '0;
			mc_valid_i <= 1'b1;
			// An interrupt far above the mask is still held off by microcode
			irq_req_i <= 1'b1;
			irq_level_i <= 3'd7;
			irq_mask_i <= 3'd0;
			capture_and_check();
		end
	endtask

	task automatic test_irq_inject();
		logic [31:0] r;
		random_group();
		r = lcg_next();
		irq_req_i <= 1'b1;
		irq_level_i <= 3'd5;
		irq_mask_i <= 3'd2;
		irq_vect_i <= r[8:0];
		capture_and_check();
		// A level equal to the mask is not taken
		random_group();
		irq_req_i <= 1'b1;
		irq_level_i <= 3'd3;
		irq_mask_i <= 3'd3;
		capture_and_check();
		random_group();
		irq_req_i <= 1'b1;
		irq_level_i <= 3'd1;
		irq_mask_i <= 3'd4;
		capture_and_check();
	endtask

	task automatic test_reglist();
		int counts [3] = '{1, 3, 4};
		logic [31:0] r;
		for (int n = 0; n < 3; n++) begin
			random_group();
			r = lcg_next();
			// Head at byte 0 with base register 30, so destinations wrap past 31
			pc_off_i[4:0] <= 5'd0;
			line_i[WB-1:0] <= {r[31:17], 5'(counts[n]), 5'd30, OP_REGLIST};
			capture_and_check();
		end
	endtask

	task automatic test_enable_reset();
		random_group();
		capture_and_check();
		// Fresh inputs with the enable low must not reach the outputs
		for (int n = 0; n < 3; n++) begin
			random_group();
			en_i <= 1'b0;
			@(posedge clk);
			@(negedge clk);
			check_outputs();
		end
		// Reset wipes every slot back to NOP
		random_group();
		rst_n_i <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		for (int i = 0; i < LANES; i++) begin
			exp_w[i] = '0;
		end
		check_outputs();
		@(posedge clk);
		rst_n_i <= 1'b1;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		rst_n_i = 1'b0;
		en_i = 1'b0;
		line_i = '0;
		pc_off_i = '0;
		mc_valid_i = 1'b0;
		mc_ins_i = '0;
		irq_req_i = 1'b0;
		irq_level_i = '0;
		irq_mask_i = '0;
		irq_vect_i = '0;
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		test_line_extract();
		test_mcode_override();
		test_irq_inject();
		test_reglist();
		test_enable_reset();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
extract_pkg.sv
extract_ctrl.sv
extract_lane.sv
extract_out.sv
extract_ins.sv
extract_assert.sv
tb_extract_ins.sv

/* run.sh */
#!/bin/sh
# Build the extract stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_extract

verilator --binary --timing --assert -f vlog.f --top-module tb_extract_ins \
	--Mdir obj_dir -o sim_extract
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	echo "Run failed, see $LOG"
	exit 1
fi

echo "Run passed"
exit 0
